//--- logic/picomem_cfg.svh
`ifndef PICOMEM_CFG_SVH
`define PICOMEM_CFG_SVH

// bus widths
`define PICOMEM_ADDR_W 32
`define PICOMEM_DATA_W 32
// one strobe bit per byte lane
`define PICOMEM_STRB_W 4

// slaves on the top-level multiplexer
`define PICOMEM_NUM_SLAVES 2

// address map
// gpio bank 0
`define PICOMEM_S0_BASE 32'h0000_0000
// gpio bank 1
`define PICOMEM_S1_BASE 32'h4000_0000
// only the top two address bits take part in the decode
`define PICOMEM_SLAVE_MASK 32'hC000_0000

// gpio register indices, from addr[3:2]
`define GPIO_REG_OUT 2'd0
`define GPIO_REG_IN 2'd1
`define GPIO_REG_OE 2'd2

// returned for the unused index 3
`define GPIO_MARKER 32'hDEAD_BEEF

// internal reset is held for 2**RESET_CNT_W - 1 cycles
`define RESET_CNT_W 4

`endif

//--- logic/picomem_pkg.sv
`default_nettype none

`include "picomem_cfg.svh"

package picomem_pkg;

  // master to slave
  // a read has all strobes low
  typedef struct packed {
    logic                         valid;
    logic [`PICOMEM_ADDR_W-1:0]   addr;
    logic [`PICOMEM_DATA_W-1:0]   wdata;
    logic [`PICOMEM_STRB_W-1:0]   wstrb;
  } picomem_req_t;

  // slave to master
  // ready is a single-cycle pulse, rdata valid with it
  typedef struct packed {
    logic                         ready;
    logic [`PICOMEM_DATA_W-1:0]   rdata;
  } picomem_rsp_t;

  // driven side of one gpio bank
  // board level combines out and oe into pads
  typedef struct packed {
    logic [`PICOMEM_DATA_W-1:0]   out;
    logic [`PICOMEM_DATA_W-1:0]   oe;
  } gpio_pins_t;

endpackage

`default_nettype wire

//--- logic/reset_sync.sv
`default_nettype none
`timescale 1ns/10ps

`include "picomem_cfg.svh"

module reset_sync (
  input  logic clk,
  input  logic ext_reset,
  output logic resetn
);

  logic [`RESET_CNT_W-1:0] cnt;

  // counts up to all ones and then holds
  always_ff @(posedge clk or negedge ext_reset) begin
    if (!ext_reset) begin
      cnt <= '0;
    end else if (!resetn) begin
      cnt <= cnt + 1'b1;
    end
  end

  // release once the counter has saturated
  assign resetn = &cnt;

endmodule

`default_nettype wire

//--- logic/picomem_mux.sv
`default_nettype none
`timescale 1ns/10ps

`include "picomem_cfg.svh"

module picomem_mux #(
  parameter int num_slaves = `PICOMEM_NUM_SLAVES,
  parameter logic [num_slaves-1:0][`PICOMEM_ADDR_W-1:0] slave_base =
    {`PICOMEM_S1_BASE, `PICOMEM_S0_BASE},
  parameter logic [num_slaves-1:0][`PICOMEM_ADDR_W-1:0] slave_mask =
    {num_slaves{`PICOMEM_SLAVE_MASK}}
) (
  input  picomem_pkg::picomem_req_t                  m_req,
  output picomem_pkg::picomem_rsp_t                  m_rsp,
  output picomem_pkg::picomem_req_t [num_slaves-1:0] s_req,
  input  picomem_pkg::picomem_rsp_t [num_slaves-1:0] s_rsp
);

  // raw address match per slave
  logic [num_slaves-1:0] hit;
  // one-hot after priority
  logic [num_slaves-1:0] sel;

  for (genvar i = 0; i < num_slaves; i++) begin : g_slave
    // only the masked bits are compared
    assign hit[i] = ~|((m_req.addr ^ slave_base[i]) & slave_mask[i]);

    // lowest index wins on overlapping windows
    if (i == 0) begin : g_first
      assign sel[i] = hit[i];
    end else begin : g_rest
      assign sel[i] = hit[i] & ~|hit[i-1:0];
    end

    // payload goes to every slave, valid only to the selected one
    assign s_req[i] = '{
      valid: m_req.valid & sel[i],
      addr:  m_req.addr,
      wdata: m_req.wdata,
      wstrb: m_req.wstrb
    };
  end

  // steer the selected response back
  // no match gives all zeros, so the access never completes
  always_comb begin
    m_rsp = '0;
    for (int i = 0; i < num_slaves; i++) begin
      if (sel[i]) begin
        m_rsp = s_rsp[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/picomem_gpio.sv
`default_nettype none
`timescale 1ns/10ps

`include "picomem_cfg.svh"

module picomem_gpio (
  input  logic                         clk,
  input  logic                         resetn,
  input  picomem_pkg::picomem_req_t    req,
  output picomem_pkg::picomem_rsp_t    rsp,
  input  logic [`PICOMEM_DATA_W-1:0]   pins_in,
  output picomem_pkg::gpio_pins_t      pins
);

  logic                       ready_q;
  logic [`PICOMEM_DATA_W-1:0] out_q;
  logic [`PICOMEM_DATA_W-1:0] oe_q;
  logic [`PICOMEM_DATA_W-1:0] rdata_q;
  logic                       accept;
  logic [1:0]                 reg_idx;

  // byte-lane merge of a write into an existing register value
  function automatic logic [`PICOMEM_DATA_W-1:0] merge_bytes(
    input logic [`PICOMEM_DATA_W-1:0] old_val,
    input logic [`PICOMEM_DATA_W-1:0] new_val,
    input logic [`PICOMEM_STRB_W-1:0] strb
  );
    logic [`PICOMEM_DATA_W-1:0] merged;
    merged = old_val;
    for (int b = 0; b < `PICOMEM_STRB_W; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // new request seen, not the tail of the previous one
  assign accept  = req.valid & ~ready_q;
  assign reg_idx = req.addr[3:2];

  // control and output registers
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      out_q   <= '0;
      oe_q    <= '0;
    end else begin
      // one-cycle ready pulse per accepted request
      ready_q <= accept;
      if (accept && reg_idx == `GPIO_REG_OUT) begin
        out_q <= merge_bytes(out_q, req.wdata, req.wstrb);
      end
      if (accept && reg_idx == `GPIO_REG_OE) begin
        oe_q <= merge_bytes(oe_q, req.wdata, req.wstrb);
      end
    end
  end

  // read data, captured alongside the ready pulse
  // out and oe give their value from before this access
  always_ff @(posedge clk) begin
    if (accept) begin
      case (reg_idx)
        `GPIO_REG_OUT: rdata_q <= out_q;
        `GPIO_REG_IN:  rdata_q <= pins_in;
        `GPIO_REG_OE:  rdata_q <= oe_q;
        default:       rdata_q <= `GPIO_MARKER;
      endcase
    end
  end

  assign rsp = '{
    ready: ready_q,
    rdata: rdata_q
  };

  assign pins = '{
    out: out_q,
    oe:  oe_q
  };

endmodule

`default_nettype wire

//--- logic/picomem_soc.sv
`default_nettype none
`timescale 1ns/10ps

`include "picomem_cfg.svh"

module picomem_soc (
  input  logic                         clk,
  input  logic                         ext_reset,
  input  picomem_pkg::picomem_req_t    bus_req,
  output picomem_pkg::picomem_rsp_t    bus_rsp,
  input  logic [`PICOMEM_DATA_W-1:0]   gpio0_in,
  input  logic [`PICOMEM_DATA_W-1:0]   gpio1_in,
  output picomem_pkg::gpio_pins_t      gpio0_pins,
  output picomem_pkg::gpio_pins_t      gpio1_pins
);

  logic resetn;

  // one request/response pair per gpio bank
  picomem_pkg::picomem_req_t [`PICOMEM_NUM_SLAVES-1:0] gpio_req;
  picomem_pkg::picomem_rsp_t [`PICOMEM_NUM_SLAVES-1:0] gpio_rsp;

  reset_sync reset_sync_inst (
    .clk       (clk),
    .ext_reset (ext_reset),
    .resetn    (resetn)
  );

  // slave 0 is bank 0, slave 1 is bank 1
  picomem_mux #(
    .num_slaves (`PICOMEM_NUM_SLAVES),
    .slave_base ({`PICOMEM_S1_BASE, `PICOMEM_S0_BASE}),
    .slave_mask ({`PICOMEM_NUM_SLAVES{`PICOMEM_SLAVE_MASK}})
  ) picomem_mux_inst (
    .m_req (bus_req),
    .m_rsp (bus_rsp),
    .s_req (gpio_req),
    .s_rsp (gpio_rsp)
  );

  picomem_gpio gpio0_inst (
    .clk     (clk),
    .resetn  (resetn),
    .req     (gpio_req[0]),
    .rsp     (gpio_rsp[0]),
    .pins_in (gpio0_in),
    .pins    (gpio0_pins)
  );

  picomem_gpio gpio1_inst (
    .clk     (clk),
    .resetn  (resetn),
    .req     (gpio_req[1]),
    .rsp     (gpio_rsp[1]),
    .pins_in (gpio1_in),
    .pins    (gpio1_pins)
  );

endmodule

`default_nettype wire

//--- test/picomem_soc_assert.sv
`default_nettype none
`timescale 1ns/10ps

`include "picomem_cfg.svh"

module picomem_soc_assert (
  input logic                      clk,
  input logic                      resetn,
  input picomem_pkg::picomem_req_t req,
  input picomem_pkg::picomem_rsp_t rsp,
  input picomem_pkg::gpio_pins_t   pins
);

  // a response only ever answers a pending request
  ready_needs_valid: assert property (
    @(posedge clk) disable iff (!resetn)
    rsp.ready |-> req.valid
  ) else $error("gpio ready high without valid");

  // the master holds its request until the bank answers
  request_held: assert property (
    @(posedge clk) disable iff (!resetn)
    (req.valid && !rsp.ready) |=>
      (req.valid && $stable(req.addr) && $stable(req.wdata) && $stable(req.wstrb))
  ) else $error("gpio request dropped or changed before ready");

  // sync reset, so the registers are cleared one edge into reset
  reset_clears_pins: assert property (
    @(posedge clk)
    (!resetn && $past(!resetn)) |-> (pins.out == '0 && pins.oe == '0)
  ) else $error("gpio out or oe not zero during reset");

endmodule

`default_nettype wire

//--- test/picomem_soc_tb.sv
`default_nettype none
`timescale 1ns/10ps

`include "picomem_cfg.svh"

module picomem_soc_tb;

  localparam int clk_period      = 8;
  localparam int reset_cycles    = 5;
  localparam int release_cycles  = 16;
  localparam int ready_limit     = 4;
  localparam int watchdog_cycles = 400;

  logic                       clk = 1'b0;
  logic                       ext_reset;
  picomem_pkg::picomem_req_t  bus_req;
  picomem_pkg::picomem_rsp_t  bus_rsp;
  logic [`PICOMEM_DATA_W-1:0] gpio0_in;
  logic [`PICOMEM_DATA_W-1:0] gpio1_in;
  picomem_pkg::gpio_pins_t    gpio0_pins;
  picomem_pkg::gpio_pins_t    gpio1_pins;

  int                         errors;
  int                         checks;
  integer                     seed;
  string                      test_name;
  // expected state of both banks
  picomem_pkg::gpio_pins_t    exp_bank0;
  picomem_pkg::gpio_pins_t    exp_bank1;

  picomem_soc picomem_soc_inst (
    .clk        (clk),
    .ext_reset  (ext_reset),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .gpio0_in   (gpio0_in),
    .gpio1_in   (gpio1_in),
    .gpio0_pins (gpio0_pins),
    .gpio1_pins (gpio1_pins)
  );

  bind picomem_gpio picomem_soc_assert picomem_soc_assert_inst (
    .clk    (clk),
    .resetn (resetn),
    .req    (req),
    .rsp    (rsp),
    .pins   (pins)
  );

  always #(clk_period / 2) clk = ~clk;

  // each set strobe bit opens one byte lane
  function automatic logic [`PICOMEM_DATA_W-1:0] lane_mask(
    input logic [`PICOMEM_STRB_W-1:0] strobes
  );
    logic [`PICOMEM_DATA_W-1:0] mask;
    for (int i = 0; i < `PICOMEM_STRB_W; i++) begin
      mask[8*i +: 8] = {8{strobes[i]}};
    end
    return mask;
  endfunction

  function automatic logic [`PICOMEM_DATA_W-1:0] written_value(
    input logic [`PICOMEM_DATA_W-1:0] old_word,
    input logic [`PICOMEM_DATA_W-1:0] new_word,
    input logic [`PICOMEM_STRB_W-1:0] strobes
  );
    return (old_word & ~lane_mask(strobes)) | (new_word & lane_mask(strobes));
  endfunction

  task automatic check_ready(input logic expected, input picomem_pkg::picomem_rsp_t actual);
    checks++;
    if (actual.ready !== expected) begin
      $display("[FAIL] %s: ready expected %b, actual %b", test_name, expected, actual.ready);
      errors++;
    end
  endtask

  task automatic check_rsp(
    input logic [`PICOMEM_DATA_W-1:0] expected,
    input picomem_pkg::picomem_rsp_t  actual
  );
    checks++;
    if (actual.rdata !== expected) begin
      $display("[FAIL] %s: rdata expected %h, actual %h", test_name, expected, actual.rdata);
      errors++;
    end
  endtask

  task automatic check_pins(
    input string                   bank,
    input picomem_pkg::gpio_pins_t expected,
    input picomem_pkg::gpio_pins_t actual
  );
    checks++;
    if (actual !== expected) begin
      $display("[FAIL] %s: %s expected out %h oe %h, actual out %h oe %h", test_name, bank,
               expected.out, expected.oe, actual.out, actual.oe);
      errors++;
    end
  endtask

  task automatic check_both_banks();
    check_pins("bank 0", exp_bank0, gpio0_pins);
    check_pins("bank 1", exp_bank1, gpio1_pins);
  endtask

  // one access, with the ready latency and width checked every time
  task automatic bus_cycle(
    input  logic [`PICOMEM_ADDR_W-1:0] address,
    input  logic [`PICOMEM_DATA_W-1:0] data,
    input  logic [`PICOMEM_STRB_W-1:0] strobes,
    output picomem_pkg::picomem_rsp_t  rsp_seen
  );
    int   cycles;
    logic seen;
    cycles   = 0;
    seen     = 1'b0;
    rsp_seen = '0;
    @(posedge clk);
    bus_req <= '{valid: 1'b1, addr: address, wdata: data, wstrb: strobes};
    while (!seen && cycles < ready_limit) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      if (bus_rsp.ready) begin
        seen     = 1'b1;
        rsp_seen = bus_rsp;
      end
    end
    @(posedge clk);
    bus_req.valid <= 1'b0;
    if (!seen) begin
      $display("%s: the bus gave no ready within %0d cycles for address %h",
               test_name, ready_limit, address);
      errors++;
    end else begin
      checks++;
      if (cycles != 1) begin
        $display("[FAIL] %s: ready latency expected 1, actual %0d", test_name, cycles);
        errors++;
      end
      // pulse must be gone one cycle later
      @(negedge clk);
      check_ready(1'b0, bus_rsp);
    end
  endtask

  task automatic bus_write(
    input logic [`PICOMEM_ADDR_W-1:0] address,
    input logic [`PICOMEM_DATA_W-1:0] data,
    input logic [`PICOMEM_STRB_W-1:0] strobes
  );
    picomem_pkg::picomem_rsp_t unused_rsp;
    bus_cycle(address, data, strobes, unused_rsp);
  endtask

  task automatic bus_read(
    input  logic [`PICOMEM_ADDR_W-1:0] address,
    output picomem_pkg::picomem_rsp_t  rsp
  );
    bus_cycle(address, '0, '0, rsp);
  endtask

  task automatic test_reset_state();
    test_name = "reset_state";
    @(negedge clk);
    check_both_banks();
    // no request yet, so no response
    repeat (3) begin
      check_ready(1'b0, bus_rsp);
      @(negedge clk);
    end
  endtask

  task automatic test_byte_strobe();
    logic [`PICOMEM_DATA_W-1:0] first_word;
    logic [`PICOMEM_DATA_W-1:0] second_word;
    picomem_pkg::picomem_rsp_t  rsp;
    test_name   = "byte_strobe";
    first_word  = $random(seed);
    second_word = $random(seed);
    bus_write(32'h0000_0000, first_word, 4'b1111);
    exp_bank0.out = written_value(exp_bank0.out, first_word, 4'b1111);
    bus_write(32'h0000_0000, second_word, 4'b0101);
    exp_bank0.out = written_value(exp_bank0.out, second_word, 4'b0101);
    check_both_banks();
    bus_read(32'h0000_0000, rsp);
    check_rsp(exp_bank0.out, rsp);
  endtask

  task automatic test_oe_and_input();
    logic [`PICOMEM_DATA_W-1:0] oe_word;
    logic [`PICOMEM_DATA_W-1:0] pin_word0;
    logic [`PICOMEM_DATA_W-1:0] pin_word1;
    picomem_pkg::picomem_rsp_t  rsp;
    test_name = "oe_and_input";
    oe_word   = $random(seed);
    pin_word0 = $random(seed);
    pin_word1 = $random(seed);
    bus_write(32'h4000_0008, oe_word, 4'b1111);
    exp_bank1.oe = oe_word;
    check_both_banks();
    bus_read(32'h4000_0008, rsp);
    check_rsp(exp_bank1.oe, rsp);
    @(posedge clk);
    gpio0_in <= pin_word0;
    gpio1_in <= pin_word1;
    bus_read(32'h4000_0004, rsp);
    check_rsp(pin_word1, rsp);
    bus_read(32'h0000_0004, rsp);
    check_rsp(pin_word0, rsp);
  endtask

  task automatic test_address_decode();
    logic [`PICOMEM_DATA_W-1:0] data;
    picomem_pkg::picomem_rsp_t  rsp;
    test_name = "address_decode";
    data = $random(seed);
    bus_write(32'h0000_0000, data, 4'b1111);
    exp_bank0.out = data;
    check_both_banks();
    data = $random(seed);
    bus_write(32'h4000_0000, data, 4'b1111);
    exp_bank1.out = data;
    check_both_banks();
    // bits below the top two are ignored by the decode
    data = $random(seed);
    bus_write(32'h3FFF_FFF0, data, 4'b1111);
    exp_bank0.out = data;
    check_both_banks();
    data = $random(seed);
    bus_write(32'h7FFF_FF08, data, 4'b0011);
    exp_bank1.oe = written_value(exp_bank1.oe, data, 4'b0011);
    check_both_banks();
    bus_read(32'h3FFF_FFF0, rsp);
    check_rsp(exp_bank0.out, rsp);
  endtask

  task automatic test_marker();
    picomem_pkg::picomem_rsp_t rsp;
    test_name = "marker";
    bus_read(32'h0000_000C, rsp);
    check_rsp(32'hDEAD_BEEF, rsp);
    bus_read(32'h4000_000C, rsp);
    check_rsp(32'hDEAD_BEEF, rsp);
    // index 3 has no storage behind it
    bus_write(32'h4000_000C, $random(seed), 4'b1111);
    check_both_banks();
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    seed      = 90;
    test_name = "reset";
    exp_bank0 = '0;
    exp_bank1 = '0;
    ext_reset <= 1'b0;
    bus_req   <= '0;
    gpio0_in  <= '0;
    gpio1_in  <= '0;
    repeat (reset_cycles) @(posedge clk);
    ext_reset <= 1'b1;
    // internal reset is still held by the release counter
    repeat (release_cycles) @(posedge clk);
    test_reset_state();
    test_byte_strobe();
    test_oe_and_input();
    test_address_decode();
    test_marker();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog: tests still running after %0d cycles", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/picomem_pkg.sv
logic/reset_sync.sv
logic/picomem_mux.sv
logic/picomem_gpio.sv
logic/picomem_soc.sv
test/picomem_soc_assert.sv
test/picomem_soc_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := picomem_soc_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := sim passed
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "no pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
